//--- Bender.yml
package:
  name: rvMemWb

sources:
  - include_dirs:
      - design
    files:
      - design/rvMemWbPkg.sv
      - design/dataMem.sv
      - design/dmemArbiter.sv
      - design/pipelineMEM.sv
      - design/pipelineWB.sv
      - design/regFile.sv
      - design/rvMemWbTop.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/rvMemWbTb.sv

//--- design/dataMem.sv
`timescale 1ns/100ps
`include "rvMemWb_cfg.svh"

module dataMem (
    input  logic                  clk,
    input  rvMemWbPkg::memReqT    req_i,   // arbitrated request
    output logic [`RVMW_XLEN-1:0] rdata_o  // word read on the previous cycle
);

    localparam int NBYTES = `RVMW_XLEN / 8; // byte lanes per word

    // ======================================================================
    // storage and access
    // ======================================================================
    logic [`RVMW_XLEN-1:0] mem [`RVMW_DMEM_WORDS]; // contents come up undefined

    always_ff @(posedge clk) begin
        if (req_i.we) begin
            for (int b = 0; b < NBYTES; b++) begin
                if (req_i.byteEn[b]) begin
                    mem[req_i.wordAddr][b*8 +: 8] <= req_i.wdata[b*8 +: 8]; // enabled lanes only
                end
            end
        end
        if (req_i.re) begin
            rdata_o <= mem[req_i.wordAddr]; // one cycle read latency
        end
    end

endmodule

//--- design/dmemArbiter.sv
`timescale 1ns/100ps
`include "rvMemWb_cfg.svh"

module dmemArbiter (
    input  logic                  clk,
    input  logic                  resetn,
    input  rvMemWbPkg::memReqT    pipeReq_i,   // memory stage request
    input  logic                  hostReq_i,   // held until granted
    input  rvMemWbPkg::memReqT    hostCmd_i,   // host access held with the request
    input  logic [`RVMW_XLEN-1:0] memRdata_i,  // registered word from the memory
    output rvMemWbPkg::memReqT    memReq_o,    // to the memory
    output logic [`RVMW_XLEN-1:0] pipeRdata_o, // returned word for the pipeline
    output logic                  hostGrant_o, // one pulse per issued host access
    output logic [`RVMW_XLEN-1:0] hostRdata_o  // host word, valid the cycle after grant
);

    logic pipeActive; // pipeline accesses memory this cycle
    logic hostOwner;  // last issued access belonged to the host

    // ======================================================================
    // fixed priority select
    // ======================================================================
    assign pipeActive  = pipeReq_i.re | pipeReq_i.we;
    assign hostGrant_o = hostReq_i & ~pipeActive;                // host only on idle pipeline cycles
    assign memReq_o    = hostGrant_o ? hostCmd_i : pipeReq_i;    // idle pipeline request is a nop

    // owner of the access now in flight in the memory
    always_ff @(posedge clk) begin
        if (!resetn) begin
            hostOwner <= 1'b0;
        end else begin
            hostOwner <= hostGrant_o;
        end
    end

    // ======================================================================
    // read data steering
    // ======================================================================
    assign pipeRdata_o = hostOwner ? '0 : memRdata_i;  // pipeline sees zero after a host slot
    assign hostRdata_o = hostOwner ? memRdata_i : '0;  // host sees only its own word

endmodule

//--- design/pipelineMEM.sv
`timescale 1ns/100ps
`include "rvMemWb_cfg.svh"

module pipelineMEM (
    input  logic                  clk,
    input  logic                  resetn,
    input  rvMemWbPkg::exToMemT   exIn_i,     // execute stage bundle
    output rvMemWbPkg::memReqT    memReq_o,   // pipeline memory request
    input  logic [`RVMW_XLEN-1:0] memRdata_i, // word for the instruction now in M
    output rvMemWbPkg::memToWbT   toWb_o      // results for write back
);

    import rvMemWbPkg::*;

    // funct3[1:0] access sizes, funct3[2] marks the unsigned loads
    localparam logic [1:0] SIZE_B = 2'b00;
    localparam logic [1:0] SIZE_H = 2'b01;
    localparam logic [1:0] SIZE_W = 2'b10;

    exToMemT               mReg;       // EX/MEM register
    dataWordU              stWord;     // store data placed on its lanes
    dataWordU              ldWord;     // returned word split into lanes
    logic [3:0]            byteEn;     // store lane enables
    logic [7:0]            ldByte;     // addressed byte of the load word
    logic [15:0]           ldHalf;     // addressed halfword of the load word
    logic                  ldSignExt;  // sign extend the narrow load
    logic [`RVMW_XLEN-1:0] loadData;   // extended load result

    // ======================================================================
    // request side, built from the unregistered EX bundle
    // ======================================================================
    always_comb begin
        stWord = dataWordU'(exIn_i.storeData); // word store default
        byteEn = 4'b1111;
        case (exIn_i.funct3[1:0])
            SIZE_B: begin
                stWord.bytes = {4{exIn_i.storeData[7:0]}};     // byte on every lane
                byteEn       = 4'b0001 << exIn_i.aluResult[1:0];
            end
            SIZE_H: begin
                stWord.halves = {2{exIn_i.storeData[15:0]}};   // halfword on both lanes
                byteEn        = exIn_i.aluResult[1] ? 4'b1100 : 4'b0011;
            end
            SIZE_W: begin
                byteEn = 4'b1111;
            end
            default: begin
                byteEn = 4'b1111;
            end
        endcase
    end

    always_comb begin
        memReq_o.we       = exIn_i.memWrite;
        memReq_o.re       = exIn_i.memRead;
        memReq_o.wordAddr = exIn_i.aluResult[DMEM_AW+1:2]; // drop the byte offset
        memReq_o.byteEn   = byteEn;
        memReq_o.wdata    = stWord;
    end

    // ======================================================================
    // EX/MEM register
    // ======================================================================
    always_ff @(posedge clk) begin
        mReg <= exIn_i;                 // payload carries no reset
        if (!resetn) begin
            mReg.regWriteEn <= 1'b0;
            mReg.memRead    <= 1'b0;
            mReg.memWrite   <= 1'b0;
        end
    end

    // ======================================================================
    // load lane select and extension
    // ======================================================================
    assign ldWord = dataWordU'(memRdata_i);

    always_comb begin
        ldByte    = ldWord.bytes[mReg.aluResult[1:0]];   // registered offset picks the lane
        ldHalf    = ldWord.halves[mReg.aluResult[1]];
        ldSignExt = ~mReg.funct3[2];                      // lb and lh
        case (mReg.funct3[1:0])
            SIZE_B:  loadData = {{(`RVMW_XLEN-8){ldSignExt & ldByte[7]}}, ldByte};
            SIZE_H:  loadData = {{(`RVMW_XLEN-16){ldSignExt & ldHalf[15]}}, ldHalf};
            default: loadData = memRdata_i;               // lw
        endcase
    end

    always_comb begin
        toWb_o.aluResult   = mReg.aluResult;
        toWb_o.loadData    = loadData;
        toWb_o.extendedImm = mReg.extendedImm;
        toWb_o.pcPlus4     = mReg.pcPlus4;
        toWb_o.regWriteEn  = mReg.regWriteEn;
        toWb_o.rd          = mReg.rd;
        toWb_o.resultSrc   = mReg.resultSrc;
    end

endmodule

//--- design/pipelineWB.sv
`timescale 1ns/100ps
`include "rvMemWb_cfg.svh"

module pipelineWB (
    input  logic                clk,
    input  logic                resetn,
    input  rvMemWbPkg::memToWbT fromMem_i,  // memory stage results
    output rvMemWbPkg::rfWriteT rfWrite_o   // registered register file write
);

    logic [`RVMW_XLEN-1:0] wbData; // selected write back value

    // ======================================================================
    // source select
    // ======================================================================
    always_comb begin
        case (fromMem_i.resultSrc)
            `RVMW_WBSRC_ALU: wbData = fromMem_i.aluResult;    // arithmetic and logic ops
            `RVMW_WBSRC_IMM: wbData = fromMem_i.extendedImm;  // lui
            `RVMW_WBSRC_MEM: wbData = fromMem_i.loadData;     // loads
            `RVMW_WBSRC_PC:  wbData = fromMem_i.pcPlus4;      // jal link
            default:         wbData = fromMem_i.aluResult;
        endcase
    end

    // ======================================================================
    // MEM/WB register
    // ======================================================================
    always_ff @(posedge clk) begin
        rfWrite_o.data <= wbData;                  // data follows without reset
        if (!resetn) begin
            rfWrite_o.we <= 1'b0;
            rfWrite_o.rd <= '0;
        end else begin
            rfWrite_o.we <= fromMem_i.regWriteEn;
            rfWrite_o.rd <= fromMem_i.rd;
        end
    end

endmodule

//--- design/regFile.sv
`timescale 1ns/100ps
`include "rvMemWb_cfg.svh"

module regFile (
    input  logic                  clk,
    input  logic                  resetn,
    input  rvMemWbPkg::rfWriteT   write_i,    // write port from write back
    input  logic [4:0]            rs1Addr_i,
    input  logic [4:0]            rs2Addr_i,
    output logic [`RVMW_XLEN-1:0] rs1Data_o,
    output logic [`RVMW_XLEN-1:0] rs2Data_o
);

    localparam int NREGS = 32; // x0 to x31

    logic [`RVMW_XLEN-1:0] regs [NREGS];

    // ======================================================================
    // write port
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int r = 0; r < NREGS; r++) begin
                regs[r] <= '0;                      // whole file cleared
            end
        end else if (write_i.we && (write_i.rd != 5'd0)) begin
            regs[write_i.rd] <= write_i.data;       // x0 never written so it stays zero
        end
    end

    // ======================================================================
    // read ports
    // ======================================================================
    assign rs1Data_o = regs[rs1Addr_i]; // no write bypass
    assign rs2Data_o = regs[rs2Addr_i];

endmodule

//--- design/rvMemWbPkg.sv
`include "rvMemWb_cfg.svh"

package rvMemWbPkg;

    localparam int DMEM_AW = $clog2(`RVMW_DMEM_WORDS); // word address width

    // ======================================================================
    // execute stage outputs captured by the memory stage
    // ======================================================================
    typedef struct packed {
        logic [`RVMW_XLEN-1:0] aluResult;   // alu result, also the memory byte address
        logic [`RVMW_XLEN-1:0] storeData;   // rs2 value for stores
        logic [`RVMW_XLEN-1:0] extendedImm; // immediate for lui
        logic [`RVMW_XLEN-1:0] pcPlus4;     // link value for jal
        logic                  regWriteEn;  // instruction writes rd
        logic                  memRead;     // load strobe
        logic                  memWrite;    // store strobe
        logic [4:0]            rd;          // destination register index
        logic [1:0]            resultSrc;   // write back source code
        logic [2:0]            funct3;      // access size and signedness
    } exToMemT;

    // one data memory access, same shape for pipeline and host
    typedef struct packed {
        logic                  we;       // write
        logic                  re;       // read
        logic [DMEM_AW-1:0]    wordAddr; // word index into the memory
        logic [3:0]            byteEn;   // per byte write enable
        logic [`RVMW_XLEN-1:0] wdata;    // lane aligned write data
    } memReqT;

    // memory stage results handed to write back
    typedef struct packed {
        logic [`RVMW_XLEN-1:0] aluResult;
        logic [`RVMW_XLEN-1:0] loadData;    // already extended
        logic [`RVMW_XLEN-1:0] extendedImm;
        logic [`RVMW_XLEN-1:0] pcPlus4;
        logic                  regWriteEn;
        logic [4:0]            rd;
        logic [1:0]            resultSrc;
    } memToWbT;

    // register file write port
    typedef struct packed {
        logic                  we;
        logic [4:0]            rd;
        logic [`RVMW_XLEN-1:0] data;
    } rfWriteT;

    // a memory word viewed by byte lane or by halfword lane
    typedef union packed {
        logic [3:0][7:0]  bytes;  // bytes[0] is address offset 0
        logic [1:0][15:0] halves; // halves[0] is address offset 0
    } dataWordU;

endpackage

//--- design/rvMemWbTop.sv
`timescale 1ns/100ps
`include "rvMemWb_cfg.svh"

module rvMemWbTop (
    input  logic                  clk,
    input  logic                  resetn,
    input  rvMemWbPkg::exToMemT   exIn_i,       // from the execute stage
    input  logic                  hostReq_i,    // loader request level
    input  rvMemWbPkg::memReqT    hostCmd_i,    // loader access
    output logic                  hostGrant_o,
    output logic [`RVMW_XLEN-1:0] hostRdata_o,
    input  logic [4:0]            rs1Addr_i,    // observation read ports
    input  logic [4:0]            rs2Addr_i,
    output logic [`RVMW_XLEN-1:0] rs1Data_o,
    output logic [`RVMW_XLEN-1:0] rs2Data_o,
    output rvMemWbPkg::rfWriteT   wbWrite_o     // register file write as it happens
);

    import rvMemWbPkg::*;

    memReqT                pipeReq;    // memory stage request
    memReqT                memReq;     // arbitrated request
    logic [`RVMW_XLEN-1:0] memRdata;   // raw memory read word
    logic [`RVMW_XLEN-1:0] pipeRdata;  // read word steered to the pipeline
    memToWbT               memToWb;    // M to W bundle

    // ======================================================================
    // memory stage and shared data memory
    // ======================================================================
    pipelineMEM uMem (
        .clk        (clk),
        .resetn     (resetn),
        .exIn_i     (exIn_i),
        .memReq_o   (pipeReq),
        .memRdata_i (pipeRdata),
        .toWb_o     (memToWb)
    );

    dmemArbiter uArb (
        .clk         (clk),
        .resetn      (resetn),
        .pipeReq_i   (pipeReq),
        .hostReq_i   (hostReq_i),
        .hostCmd_i   (hostCmd_i),
        .memRdata_i  (memRdata),
        .memReq_o    (memReq),
        .pipeRdata_o (pipeRdata),
        .hostGrant_o (hostGrant_o),
        .hostRdata_o (hostRdata_o)
    );

    dataMem uDmem (
        .clk     (clk),
        .req_i   (memReq),
        .rdata_o (memRdata)
    );

    // ======================================================================
    // write back and register file
    // ======================================================================
    pipelineWB uWb (
        .clk       (clk),
        .resetn    (resetn),
        .fromMem_i (memToWb),
        .rfWrite_o (wbWrite_o)     // also the register file write port
    );

    regFile uRf (
        .clk       (clk),
        .resetn    (resetn),
        .write_i   (wbWrite_o),
        .rs1Addr_i (rs1Addr_i),
        .rs2Addr_i (rs2Addr_i),
        .rs1Data_o (rs1Data_o),
        .rs2Data_o (rs2Data_o)
    );

endmodule

//--- design/rvMemWb_cfg.svh
`ifndef RVMEMWB_CFG_SVH
`define RVMEMWB_CFG_SVH

// ======================================================================
// datapath and memory sizing
// ======================================================================
`define RVMW_XLEN        32     // register and memory word width
`define RVMW_DMEM_WORDS  1024   // data memory depth in words

// ======================================================================
// write back source select codes
// ======================================================================
`define RVMW_WBSRC_ALU   2'b00  // alu result
`define RVMW_WBSRC_IMM   2'b01  // extended immediate for lui
`define RVMW_WBSRC_MEM   2'b10  // extended load data
`define RVMW_WBSRC_PC    2'b11  // pc+4 for jal and jalr

`endif

//--- rvMemWb.f
+incdir+design
design/rvMemWbPkg.sv
design/dataMem.sv
design/dmemArbiter.sv
design/pipelineMEM.sv
design/pipelineWB.sv
design/regFile.sv
design/rvMemWbTop.sv
verification/rvMemWbTb.sv

//--- verification/rvMemWbTb.sv
`timescale 1ns/100ps
`include "rvMemWb_cfg.svh"

module rvMemWbTb;

    import rvMemWbPkg::*;

    localparam int ALU_OPS   = 24;   // test 2 issues
    localparam int MEM_WORDS = 16;   // words of the load/store region
    localparam int MEM_OPS   = 32;   // stores, then as many loads
    localparam int X0_OPS    = 4;
    localparam int ARB_LOADS = 6;    // loads that hold the host off
    localparam int MIX_OPS   = 120;
    localparam int TOTAL_OPS = ALU_OPS + MEM_WORDS + 2 * MEM_OPS + X0_OPS + ARB_LOADS + 1 + MIX_OPS;
    localparam int TIMEOUT_CYCLES = 4 * TOTAL_OPS + 200;
    localparam int GRANT_WAIT = 16;  // cycles a host request may wait on an idle pipeline
    localparam logic [31:0] MEM_BASE = 32'h100;

    localparam int K_ALU   = 0;      // instruction kinds
    localparam int K_IMM   = 1;
    localparam int K_PC    = 2;
    localparam int K_STORE = 3;
    localparam int K_LOAD  = 4;

    typedef struct packed {
        logic [31:0] due;            // cycle in which wbWrite_o must show it
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
    } wbExpT;

    logic clk;
    logic resetn;
    exToMemT exIn;
    logic hostReq;
    memReqT hostCmd;
    logic hostGrant;
    logic [31:0] hostRdata;
    logic [4:0] rs1Addr;
    logic [4:0] rs2Addr;
    logic [31:0] rs1Data;
    logic [31:0] rs2Data;
    rfWriteT wbWrite;

    logic [31:0] mdlMem [`RVMW_DMEM_WORDS]; // reference data memory
    logic [31:0] mdlRegs [32];              // reference register file
    wbExpT expQ [$];                        // write-backs in program order
    wbExpT wbExp;
    integer seed = 32'heaec;
    int cycleCount;
    int errorCount = 0;
    int testCount = 0;
    int testErrBase;
    string curTest = "reset";

    rvMemWbTop UUT (
        .clk         (clk),
        .resetn      (resetn),
        .exIn_i      (exIn),
        .hostReq_i   (hostReq),
        .hostCmd_i   (hostCmd),
        .hostGrant_o (hostGrant),
        .hostRdata_o (hostRdata),
        .rs1Addr_i   (rs1Addr),
        .rs2Addr_i   (rs2Addr),
        .rs1Data_o   (rs1Data),
        .rs2Data_o   (rs2Data),
        .wbWrite_o   (wbWrite)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;       // 8 ns period
    end

    // ======================================================================
    // reference model
    // ======================================================================
    function automatic logic [31:0] refResult(input exToMemT op);
        logic [31:0] word;
        logic [31:0] lane;
        logic [31:0] res;
        word = mdlMem[op.aluResult[DMEM_AW+1:2]];
        lane = word >> (8 * op.aluResult[1:0]);     // addressed lane moved to bit 0
        case (op.resultSrc)
            `RVMW_WBSRC_IMM: res = op.extendedImm;
            `RVMW_WBSRC_PC:  res = op.pcPlus4;
            `RVMW_WBSRC_MEM: begin
                case (op.funct3)
                    3'b000:  res = {{24{lane[7]}}, lane[7:0]};    // lb
                    3'b001:  res = {{16{lane[15]}}, lane[15:0]};  // lh
                    3'b100:  res = {24'd0, lane[7:0]};            // lbu
                    3'b101:  res = {16'd0, lane[15:0]};           // lhu
                    default: res = word;                          // lw
                endcase
            end
            default: res = op.aluResult;
        endcase
        return res;
    endfunction

    task automatic modelStore(input exToMemT op);
        logic [DMEM_AW-1:0] wa;
        wa = op.aluResult[DMEM_AW+1:2];
        case (op.funct3[1:0])
            2'b00:   mdlMem[wa][8 * op.aluResult[1:0] +: 8] = op.storeData[7:0];
            2'b01:   mdlMem[wa][16 * op.aluResult[1] +: 16] = op.storeData[15:0];
            default: mdlMem[wa] = op.storeData;
        endcase
    endtask

    function automatic logic [31:0] randMemAddr(input logic [1:0] size);
        logic [1:0] off;
        off = $random(seed);
        if (size == 2'b01) off[0] = 1'b0;            // halfwords aligned
        if (size == 2'b10) off = 2'b00;              // words aligned
        return MEM_BASE + 4 * ($unsigned($random(seed)) % MEM_WORDS) + off;
    endfunction

    function automatic exToMemT buildOp(input int kind);
        exToMemT op;
        logic [1:0] size;
        op.aluResult   = $random(seed);
        op.storeData   = $random(seed);
        op.extendedImm = $random(seed);
        op.pcPlus4     = $random(seed);
        op.rd          = 5'd1 + ($unsigned($random(seed)) % 31);
        op.regWriteEn  = 1'b1;
        op.memRead     = 1'b0;
        op.memWrite    = 1'b0;
        op.resultSrc   = `RVMW_WBSRC_ALU;
        op.funct3      = $random(seed);
        size           = $unsigned($random(seed)) % 3;
        case (kind)
            K_IMM: op.resultSrc = `RVMW_WBSRC_IMM;
            K_PC:  op.resultSrc = `RVMW_WBSRC_PC;
            K_STORE: begin
                op.regWriteEn = 1'b0;
                op.memWrite   = 1'b1;
                op.funct3     = {1'b0, size};           // sb sh sw
                op.aluResult  = randMemAddr(size);
            end
            K_LOAD: begin
                op.memRead   = 1'b1;
                op.resultSrc = `RVMW_WBSRC_MEM;
                op.funct3    = {(size != 2'b10) & op.funct3[2], size}; // unsigned only when narrow
                op.aluResult = randMemAddr(size);
            end
            default: ;
        endcase
        return op;
    endfunction

    // ======================================================================
    // drive and check helpers
    // ======================================================================
    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic driveOp(input exToMemT op);
        wbExpT e;
        e.due  = cycleCount + 2;                     // M at t+1, W register at t+2
        e.we   = op.regWriteEn;
        e.rd   = op.rd;
        e.data = refResult(op);
        expQ.push_back(e);
        if (op.memWrite) modelStore(op);
        if (op.regWriteEn && op.rd != 5'd0) mdlRegs[op.rd] = e.data;
        exIn = op;
    endtask

    task automatic issueOp(input exToMemT op);
        @(posedge clk);
        #1;
        driveOp(op);
    endtask

    task automatic idleCycle();
        @(posedge clk);
        #1;
        exIn = '0;                                   // bubble, no strobes
    endtask

    task automatic waitGrant(output int waited);
        waited = 0;
        @(negedge clk);
        while (!hostGrant && waited < GRANT_WAIT) begin
            idleCycle();
            @(negedge clk);
            waited++;
        end
        if (!hostGrant) begin
            $display("%s: host grant did not arrive within %0d cycles", curTest, GRANT_WAIT);
            errorCount++;
        end
    endtask

    task automatic checkRegs(input string name);
        for (int r = 0; r < 16; r++) begin
            @(posedge clk);
            #1;
            rs1Addr = r;
            rs2Addr = r + 16;
            @(negedge clk);
            checkValue({name, " readback"}, mdlRegs[r], rs1Data);
            checkValue({name, " readback"}, mdlRegs[r + 16], rs2Data);
        end
    endtask

    task automatic startTest(input string name);
        curTest = name;
        testErrBase = errorCount;
    endtask

    task automatic finishTest();
        repeat (4) idleCycle();                      // let three in flight retire
        @(negedge clk);
        if (expQ.size() != 0) begin
            $display("%s: %0d write-backs never appeared", curTest, expQ.size());
            errorCount++;
        end
        checkRegs(curTest);
        testCount++;
        $display("test %-12s %s (%0d errors)", curTest,
                 (errorCount == testErrBase) ? "ok" : "failed", errorCount - testErrBase);
    endtask

    // ======================================================================
    // scoreboard, one compare per cycle at the falling edge
    // ======================================================================
    always @(negedge clk) begin
        if (resetn) begin
            if (expQ.size() > 0 && expQ[0].due == cycleCount) begin
                wbExp = expQ.pop_front();
                checkValue({curTest, " we"}, wbExp.we, wbWrite.we);
                if (wbExp.we) begin
                    checkValue({curTest, " rd"}, wbExp.rd, wbWrite.rd);
                    checkValue({curTest, " data"}, wbExp.data, wbWrite.data);
                end
            end else begin
                checkValue({curTest, " idle we"}, 32'd0, wbWrite.we); // no spurious writes
            end
        end
    end

    initial begin : watchdog
        cycleCount = 0;
        while (cycleCount < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    // ======================================================================
    // stimulus
    // ======================================================================
    initial begin : stimulus
        exToMemT op;
        int waited;
        logic [31:0] hostData;
        resetn  = 1'b0;
        exIn    = buildOp(K_ALU);                    // register write strobe held under reset
        hostReq = 1'b0;
        hostCmd = '0;
        rs1Addr = '0;
        rs2Addr = '0;
        for (int r = 0; r < 32; r++) mdlRegs[r] = '0;
        repeat (5) @(posedge clk);
        #1;
        resetn = 1'b1;
        exIn   = '0;

        startTest("reset");
        @(negedge clk);
        checkValue("reset we", 32'd0, wbWrite.we);
        checkValue("reset grant", 32'd0, hostGrant);
        finishTest();

        startTest("sources");
        for (int i = 0; i < ALU_OPS; i++) issueOp(buildOp(K_ALU + $unsigned($random(seed)) % 3));
        finishTest();

        startTest("loadstore");
        for (int i = 0; i < MEM_WORDS; i++) begin
            op = buildOp(K_STORE);
            op.funct3    = 3'b010;                   // fill the region with words first
            op.aluResult = MEM_BASE + 4 * i;
            issueOp(op);
        end
        for (int i = 0; i < MEM_OPS; i++) issueOp(buildOp(K_STORE));
        for (int i = 0; i < MEM_OPS; i++) issueOp(buildOp(K_LOAD));
        finishTest();

        startTest("x0write");
        for (int i = 0; i < X0_OPS; i++) begin
            op = buildOp(K_ALU);
            op.rd = 5'd0;
            issueOp(op);
        end
        finishTest();

        startTest("arbitration");
        hostData = $random(seed);
        @(posedge clk);
        #1;
        hostReq = 1'b1;                              // host write held from here
        hostCmd = '{we: 1'b1, re: 1'b0, wordAddr: (MEM_BASE >> 2) + 3, byteEn: 4'hF,
                    wdata: hostData};
        driveOp(buildOp(K_LOAD));
        for (int i = 1; i <= ARB_LOADS; i++) begin
            @(negedge clk);
            checkValue("arbitration busy grant", 32'd0, hostGrant);
            if (i < ARB_LOADS) issueOp(buildOp(K_LOAD));
        end
        idleCycle();
        waitGrant(waited);
        checkValue("arbitration grant delay", 32'd0, waited);
        mdlMem[(MEM_BASE >> 2) + 3] = hostData;
        op = buildOp(K_LOAD);
        op.funct3    = 3'b010;
        op.aluResult = MEM_BASE + 12;
        @(posedge clk);
        #1;
        hostReq = 1'b0;
        driveOp(op);                                 // pipeline lw of the host word
        idleCycle();
        hostReq = 1'b1;
        hostCmd.we = 1'b0;                           // host read of the same word
        hostCmd.re = 1'b1;
        waitGrant(waited);
        idleCycle();
        hostReq = 1'b0;
        @(negedge clk);
        checkValue("arbitration host read", hostData, hostRdata);
        finishTest();

        startTest("mix");
        for (int i = 0; i < MIX_OPS; i++) issueOp(buildOp($unsigned($random(seed)) % 5));
        finishTest();

        $display("tests %0d, errors %0d", testCount, errorCount);
        if (errorCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
